//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
TOP       := tb_vlane_top
FILELIST  := project.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hdl/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/lane_alu.sv
module lane_alu
   import vlane_pkg::*;
(
   input  alu_op_e           alu_op_i,
   input  op2_sel_e          op2_sel_i,
   input  logic [DATA_W-1:0] vs1_i,
   input  logic [DATA_W-1:0] vs2_i,
   input  logic [DATA_W-1:0] scalar_i,
   input  logic [IMM_W-1:0]  imm_i,
   output logic [DATA_W-1:0] result_o
);

   logic [DATA_W-1:0]  imm_ext;
   logic [DATA_W-1:0]  op2;
   logic [SHAMT_W-1:0] shamt;

   assign imm_ext = {{(DATA_W - IMM_W){imm_i[IMM_W-1]}}, imm_i};
   assign shamt   = op2[SHAMT_W-1:0];

   ////////////////////
   // Operand select
   ////////////////////
   always_comb
   begin
      case (op2_sel_i)
         OP2_SCALAR: op2 = scalar_i;
         OP2_IMM:    op2 = imm_ext;
         default:    op2 = vs2_i;
      endcase
   end

   ////////////////////
   // Operations
   ////////////////////
   always_comb
   begin
      case (alu_op_i)
         ALU_ADD: result_o = vs1_i + op2;
         ALU_SUB: result_o = vs1_i - op2;
         ALU_AND: result_o = vs1_i & op2;
         ALU_OR:  result_o = vs1_i | op2;
         ALU_XOR: result_o = vs1_i ^ op2;
         ALU_SLL: result_o = vs1_i << shamt;
         ALU_SRL: result_o = vs1_i >> shamt;                // Logical, zero fill
         default: result_o = vs1_i;
      endcase
   end

endmodule

//--- hdl/slide_ring.sv
module slide_ring
   import vlane_pkg::*;
(
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  logic                             advance_i,
   input  logic                             ring_first_i,
   input  logic [DATA_W-1:0]                scalar_i,
   input  logic [LANE_NUM-1:0][DATA_W-1:0]  ring_i,
   output logic [LANE_NUM-1:0][DATA_W-1:0]  slide_o
);

   logic [DATA_W-1:0] wrap_q;

   // Last lane of this row feeds lane 0 of the next
   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         wrap_q <= '0;
      else if (advance_i)
         wrap_q <= ring_i[LANE_NUM-1];
   end

   ////////////////////
   // Shift up by one
   ////////////////////
   always_comb
   begin
      slide_o[0] = ring_first_i ? scalar_i : wrap_q;       // Element 0 takes the scalar
      for (int l = 1; l < LANE_NUM; l++)
      begin
         slide_o[l] = ring_i[l-1];
      end
   end

endmodule

//--- hdl/vector_lane.sv
module vector_lane
   import vlane_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              rd_en_i,
   input  logic [VRF_AW-1:0] rd_addr_a_i,
   input  logic [VRF_AW-1:0] rd_addr_b_i,
   input  logic [VRF_AW-1:0] wr_addr_i,
   input  logic              wr_en_i,
   input  logic              res_en_i,
   input  logic              store_en_i,
   input  wb_sel_e           wb_sel_i,
   input  alu_op_e           alu_op_i,
   input  op2_sel_e          op2_sel_i,
   input  logic [DATA_W-1:0] scalar_i,
   input  logic [IMM_W-1:0]  imm_i,
   input  logic [DATA_W-1:0] load_data_i,
   input  logic [DATA_W-1:0] slide_in_i,
   output logic [DATA_W-1:0] ring_out_o,
   output logic [DATA_W-1:0] store_data_o,
   output logic              store_valid_o
);

   logic [DATA_W-1:0] rd_data_a, rd_data_b;
   logic [DATA_W-1:0] alu_result;
   logic [DATA_W-1:0] wb_data;
   logic [DATA_W-1:0] res_q;

   vrf_bank u_vrf (
      .clk_i       (clk_i),
      .rd_en_i     (rd_en_i),
      .rd_addr_a_i (rd_addr_a_i),
      .rd_addr_b_i (rd_addr_b_i),
      .wr_en_i     (wr_en_i),
      .wr_addr_i   (wr_addr_i),
      .wr_data_i   (res_q),
      .rd_data_a_o (rd_data_a),
      .rd_data_b_o (rd_data_b)
   );

   lane_alu u_alu (
      .alu_op_i  (alu_op_i),
      .op2_sel_i (op2_sel_i),
      .vs1_i     (rd_data_a),
      .vs2_i     (rd_data_b),
      .scalar_i  (scalar_i),
      .imm_i     (imm_i),
      .result_o  (alu_result)
   );

   ////////////////////
   // Writeback
   ////////////////////
   always_comb
   begin
      case (wb_sel_i)
         WB_LOAD:  wb_data = load_data_i;
         WB_SLIDE: wb_data = slide_in_i;                    // From neighbour lane
         default:  wb_data = alu_result;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (res_en_i)
         res_q <= wb_data;
   end

   // Strobe lines up with port B data
   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         store_valid_o <= 1'b0;
      else
         store_valid_o <= store_en_i;
   end

   assign ring_out_o   = rd_data_b;
   assign store_data_o = rd_data_b;

endmodule

//--- hdl/vlane_pkg.sv
package vlane_pkg;

   ////////////////////
   // Sizes
   ////////////////////
   localparam int LANE_NUM  = 4;
   localparam int DATA_W    = 32;
   localparam int VREG_NUM  = 8;
   localparam int ROWS_MAX  = 4;                            // Rows per vector register
   localparam int IMM_W     = 5;

   // Derived widths
   localparam int LANE_W    = $clog2(LANE_NUM);
   localparam int ROW_W     = $clog2(ROWS_MAX);
   localparam int VREG_W    = $clog2(VREG_NUM);
   localparam int VL_W      = $clog2(LANE_NUM * ROWS_MAX) + 1; // Holds 1 to 16
   localparam int VRF_DEPTH = VREG_NUM * ROWS_MAX;
   localparam int VRF_AW    = VREG_W + ROW_W;
   localparam int SHAMT_W   = $clog2(DATA_W);

   ////////////////////
   // Encodings
   ////////////////////
   typedef enum logic [1:0] {
      INST_LOAD,
      INST_STORE,
      INST_ARITH,
      INST_SLIDE                                            // Slide one element up
   } inst_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLL,
      ALU_SRL
   } alu_op_e;

   typedef enum logic [1:0] {
      OP2_VEC,
      OP2_SCALAR,
      OP2_IMM
   } op2_sel_e;

   typedef enum logic [1:0] {
      WB_ALU,
      WB_LOAD,
      WB_SLIDE
   } wb_sel_e;

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_READ,                                             // One row read per cycle
      SEQ_LOAD,                                             // Waiting for load rows
      SEQ_DRAIN                                             // Writebacks still in flight
   } seq_state_e;

endpackage

//--- hdl/vlane_sequencer.sv
module vlane_sequencer
   import vlane_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                start_i,
   input  inst_e               inst_i,
   input  logic [VREG_W-1:0]   vd_i,
   input  logic [VREG_W-1:0]   vs1_i,
   input  logic [VREG_W-1:0]   vs2_i,
   input  logic [VL_W-1:0]     vl_i,
   input  alu_op_e             alu_op_i,
   input  op2_sel_e            op2_sel_i,
   input  logic [DATA_W-1:0]   scalar_i,
   input  logic [IMM_W-1:0]    imm_i,
   input  logic                load_valid_i,
   output logic                ready_o,
   output logic                ready_for_load_o,
   output logic                rd_en_o,
   output logic [VRF_AW-1:0]   rd_addr_a_o,
   output logic [VRF_AW-1:0]   rd_addr_b_o,
   output logic [VRF_AW-1:0]   wr_addr_o,
   output logic [LANE_NUM-1:0] wr_en_o,
   output logic [LANE_NUM-1:0] store_en_o,
   output logic                res_en_o,
   output logic                ring_first_o,
   output wb_sel_e             wb_sel_o,
   output alu_op_e             alu_op_o,
   output op2_sel_e            op2_sel_o,
   output logic [DATA_W-1:0]   scalar_o,
   output logic [IMM_W-1:0]    imm_o
);

   seq_state_e          state_q;
   inst_e               inst_q;
   logic [VREG_W-1:0]   vd_q, vs1_q, vs2_q;
   logic [VL_W-1:0]     vl_q;
   logic [VL_W-1:0]     vl_last;
   logic [ROW_W-1:0]    row_q;
   logic [ROW_W-1:0]    last_row;
   logic [LANE_NUM-1:0] cur_en;
   logic                issue, load_take, wr_inst;
   logic                s1_v, s1_first;
   logic [VRF_AW-1:0]   s1_addr, s2_addr;
   logic [LANE_NUM-1:0] s1_en, s2_en;

   assign vl_last   = vl_q - 1'b1;
   assign last_row  = vl_last[LANE_W +: ROW_W];
   assign issue     = state_q == SEQ_READ;
   assign load_take = (state_q == SEQ_LOAD) && load_valid_i;
   assign wr_inst   = inst_q != INST_STORE;

   // Element row*LANE_NUM+lane is live while below vl
   always_comb
   begin
      for (int l = 0; l < LANE_NUM; l++)
      begin
         cur_en[l] = VL_W'({row_q, LANE_W'(l)}) < vl_q;
      end
   end

   ////////////////////
   // Instruction FSM
   ////////////////////
   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         state_q <= SEQ_IDLE;
         row_q   <= '0;
      end
      else
      begin
         case (state_q)
            SEQ_IDLE:
            begin
               if (start_i)
               begin
                  row_q   <= '0;
                  state_q <= (inst_i == INST_LOAD) ? SEQ_LOAD : SEQ_READ;
               end
            end
            SEQ_READ, SEQ_LOAD:
            begin
               if (issue || load_take)
               begin
                  if (row_q == last_row)
                     state_q <= SEQ_DRAIN;
                  else
                     row_q <= row_q + 1'b1;
               end
            end
            SEQ_DRAIN:
            begin
               if (!s1_v)                                   // Last write happens this cycle
                  state_q <= SEQ_IDLE;
            end
            default: state_q <= SEQ_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (state_q == SEQ_IDLE && start_i)
      begin
         inst_q    <= inst_i;
         vd_q      <= vd_i;
         vs1_q     <= vs1_i;
         vs2_q     <= vs2_i;
         vl_q      <= vl_i;
         alu_op_o  <= alu_op_i;
         op2_sel_o <= op2_sel_i;
         scalar_o  <= scalar_i;
         imm_o     <= imm_i;
      end
   end

   ////////////////////
   // Writeback pipeline
   ////////////////////
   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         s1_v     <= 1'b0;
         s1_first <= 1'b0;
         s2_en    <= '0;
      end
      else
      begin
         s1_v     <= issue && wr_inst;
         s1_first <= issue && (row_q == '0);
         if (load_take)
            s2_en <= cur_en;
         else if (s1_v)
            s2_en <= s1_en;
         else
            s2_en <= '0;
      end
   end

   // Address is vreg*ROWS_MAX + row
   always_ff @(posedge clk_i)
   begin
      s1_en   <= cur_en;
      s1_addr <= {vd_q, row_q};
      s2_addr <= load_take ? {vd_q, row_q} : s1_addr;
   end

   always_comb
   begin
      case (inst_q)
         INST_LOAD:  wb_sel_o = WB_LOAD;
         INST_SLIDE: wb_sel_o = WB_SLIDE;
         default:    wb_sel_o = WB_ALU;
      endcase
   end

   assign ready_o          = state_q == SEQ_IDLE;
   assign ready_for_load_o = state_q == SEQ_LOAD;
   assign rd_en_o          = issue;
   assign rd_addr_a_o      = {vs1_q, row_q};
   assign rd_addr_b_o      = {vs2_q, row_q};
   assign store_en_o       = (issue && !wr_inst) ? cur_en : '0;
   assign res_en_o         = s1_v || load_take;
   assign ring_first_o     = s1_first;
   assign wr_addr_o        = s2_addr;
   assign wr_en_o          = s2_en;

endmodule

//--- hdl/vlane_top.sv
module vlane_top
   import vlane_pkg::*;
(
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  logic                             start_i,
   input  inst_e                            inst_i,
   input  logic [VREG_W-1:0]                vd_i,
   input  logic [VREG_W-1:0]                vs1_i,
   input  logic [VREG_W-1:0]                vs2_i,
   input  logic [VL_W-1:0]                  vl_i,
   input  alu_op_e                          alu_op_i,
   input  op2_sel_e                         op2_sel_i,
   input  logic [DATA_W-1:0]                scalar_i,
   input  logic [IMM_W-1:0]                 imm_i,
   output logic                             ready_o,
   input  logic                             load_valid_i,
   output logic                             ready_for_load_o,
   input  logic [LANE_NUM-1:0][DATA_W-1:0]  load_data_i,
   output logic [LANE_NUM-1:0][DATA_W-1:0]  store_data_o,
   output logic [LANE_NUM-1:0]              store_valid_o
);

   logic                            rd_en, res_en, ring_first;
   logic [VRF_AW-1:0]               rd_addr_a, rd_addr_b, wr_addr;
   logic [LANE_NUM-1:0]             wr_en, store_en;
   wb_sel_e                         wb_sel;
   alu_op_e                         alu_op;
   op2_sel_e                        op2_sel;
   logic [DATA_W-1:0]               scalar;
   logic [IMM_W-1:0]                imm;
   logic [LANE_NUM-1:0][DATA_W-1:0] ring_out, slide_in;

   vlane_sequencer u_seq (
      .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i), .inst_i(inst_i),
      .vd_i(vd_i), .vs1_i(vs1_i), .vs2_i(vs2_i), .vl_i(vl_i),
      .alu_op_i(alu_op_i), .op2_sel_i(op2_sel_i), .scalar_i(scalar_i), .imm_i(imm_i),
      .load_valid_i(load_valid_i), .ready_o(ready_o), .ready_for_load_o(ready_for_load_o),
      .rd_en_o(rd_en), .rd_addr_a_o(rd_addr_a), .rd_addr_b_o(rd_addr_b),
      .wr_addr_o(wr_addr), .wr_en_o(wr_en), .store_en_o(store_en),
      .res_en_o(res_en), .ring_first_o(ring_first), .wb_sel_o(wb_sel),
      .alu_op_o(alu_op), .op2_sel_o(op2_sel), .scalar_o(scalar), .imm_o(imm)
   );

   ////////////////////
   // Lanes
   ////////////////////
   for (genvar l = 0; l < LANE_NUM; l++)
   begin : g_lane
      vector_lane u_lane (
         .clk_i(clk_i), .rst_i(rst_i), .rd_en_i(rd_en),
         .rd_addr_a_i(rd_addr_a), .rd_addr_b_i(rd_addr_b),
         .wr_addr_i(wr_addr), .wr_en_i(wr_en[l]),
         .res_en_i(res_en), .store_en_i(store_en[l]), .wb_sel_i(wb_sel),
         .alu_op_i(alu_op), .op2_sel_i(op2_sel), .scalar_i(scalar), .imm_i(imm),
         .load_data_i(load_data_i[l]), .slide_in_i(slide_in[l]),
         .ring_out_o(ring_out[l]), .store_data_o(store_data_o[l]),
         .store_valid_o(store_valid_o[l])
      );
   end

   // Ring advances with each written row of read data
   slide_ring u_ring (
      .clk_i(clk_i), .rst_i(rst_i), .advance_i(res_en), .ring_first_i(ring_first),
      .scalar_i(scalar), .ring_i(ring_out), .slide_o(slide_in)
   );

endmodule

//--- hdl/vrf_bank.sv
module vrf_bank
   import vlane_pkg::*;
(
   input  logic              clk_i,
   input  logic              rd_en_i,
   input  logic [VRF_AW-1:0] rd_addr_a_i,
   input  logic [VRF_AW-1:0] rd_addr_b_i,
   input  logic              wr_en_i,
   input  logic [VRF_AW-1:0] wr_addr_i,
   input  logic [DATA_W-1:0] wr_data_i,
   output logic [DATA_W-1:0] rd_data_a_o,
   output logic [DATA_W-1:0] rd_data_b_o
);

   logic [DATA_W-1:0] mem [VRF_DEPTH];

   ////////////////////
   // Write port
   ////////////////////
   always_ff @(posedge clk_i)
   begin
      if (wr_en_i)
      begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   ////////////////////
   // Read ports
   ////////////////////

   // Same address as a write in this cycle sees the old word
   always_ff @(posedge clk_i)
   begin
      if (rd_en_i)
      begin
         rd_data_a_o <= mem[rd_addr_a_i];                   // vs1 row
         rd_data_b_o <= mem[rd_addr_b_i];                   // vs2 row
      end
   end

endmodule

//--- project.f
+incdir+test
hdl/vlane_pkg.sv
hdl/vrf_bank.sv
hdl/lane_alu.sv
hdl/vector_lane.sv
hdl/slide_ring.sv
hdl/vlane_sequencer.sv
hdl/vlane_top.sv
test/tb_vlane_top.sv

//--- test/tb_vlane_model.svh
`ifndef TB_VLANE_MODEL_SVH
`define TB_VLANE_MODEL_SVH

// Shadow register file, indexed by element
logic [DATA_W-1:0] shadow [VREG_NUM][LANE_NUM*ROWS_MAX];

function automatic logic [DATA_W-1:0] apply_op(input alu_op_e op,
                                               input logic [DATA_W-1:0] a,
                                               input logic [DATA_W-1:0] b);
   case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];                          // Low 5 bits only
      ALU_SRL: return a >> b[4:0];
      default: return '0;
   endcase
endfunction

task automatic predict_load(input logic [VREG_W-1:0] vd, input logic [VL_W-1:0] vl,
                            input logic [DATA_W-1:0] vals [LANE_NUM*ROWS_MAX]);
   for (int e = 0; e < vl; e++)
      shadow[vd][e] = vals[e];
endtask

task automatic predict_arith(input logic [VREG_W-1:0] vd, vs1, vs2,
                             input logic [VL_W-1:0] vl, input alu_op_e op,
                             input op2_sel_e sel, input logic [DATA_W-1:0] scalar,
                             input logic [IMM_W-1:0] imm);
   logic [DATA_W-1:0] a [LANE_NUM*ROWS_MAX];
   logic [DATA_W-1:0] b [LANE_NUM*ROWS_MAX];
   logic [DATA_W-1:0] operand;
   for (int e = 0; e < LANE_NUM*ROWS_MAX; e++)
   begin
      a[e] = shadow[vs1][e];
      b[e] = shadow[vs2][e];
   end
   for (int e = 0; e < vl; e++)
   begin
      case (sel)
         OP2_SCALAR: operand = scalar;
         OP2_IMM:    operand = DATA_W'($signed(imm));
         default:    operand = b[e];
      endcase
      shadow[vd][e] = apply_op(op, a[e], operand);
   end
endtask

// Sources copied first so vd may equal vs2
task automatic predict_slide(input logic [VREG_W-1:0] vd, vs2, input logic [VL_W-1:0] vl,
                             input logic [DATA_W-1:0] scalar);
   logic [DATA_W-1:0] src [LANE_NUM*ROWS_MAX];
   for (int e = 0; e < LANE_NUM*ROWS_MAX; e++)
      src[e] = shadow[vs2][e];
   for (int e = 0; e < vl; e++)
   begin
      if (e == 0)
         shadow[vd][e] = scalar;
      else
         shadow[vd][e] = src[e-1];
   end
endtask

`endif

//--- test/tb_vlane_top.sv
module tb_vlane_top
   import vlane_pkg::*;
();

   logic                            clk_i = 1'b0;
   logic                            rst_i, start_i, load_valid_i;
   inst_e                           inst_i;
   logic [VREG_W-1:0]               vd_i, vs1_i, vs2_i;
   logic [VL_W-1:0]                 vl_i;
   alu_op_e                         alu_op_i;
   op2_sel_e                        op2_sel_i;
   logic [DATA_W-1:0]               scalar_i;
   logic [IMM_W-1:0]                imm_i;
   logic [LANE_NUM-1:0][DATA_W-1:0] load_data_i, store_data_o;
   logic                            ready_o, ready_for_load_o;
   logic [LANE_NUM-1:0]             store_valid_o;

   int                seed = 77;
   int                cycle_cnt = 0;
   int                strobe_row = 0;
   int                strobe_cnt = 0;
   inst_e             cur_inst = INST_STORE;
   logic [VREG_W-1:0] store_reg = '0;
   logic [VL_W-1:0]   store_vl = '0;

   `include "tb_vlane_model.svh"

   vlane_top DUT (.*);

   always #50 clk_i = ~clk_i;

   task automatic report_failure(input string line);
      $display("Test failed");
      $display("%s", line);
      $fatal(1, "Simulation stopped on error");
   endtask

   // About 90 instructions of up to 20 cycles each
   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == 2000)
         report_failure("Run did not finish within 2000 clock cycles");
   end

   // Rows strobed by the store in flight
   always @(posedge clk_i)
   begin
      if (!rst_i || (start_i && ready_o))
      begin
         strobe_row <= 0;
         strobe_cnt <= 0;
      end
      else if (|store_valid_o)
      begin
         strobe_row <= strobe_row + 1;
         strobe_cnt <= strobe_cnt + $countones(store_valid_o);
      end
   end

   function automatic logic [DATA_W-1:0] expected_elem(input int lane);
      return shadow[store_reg][strobe_row*LANE_NUM + lane];
   endfunction

   function automatic logic [LANE_NUM-1:0] expected_mask();
      logic [LANE_NUM-1:0] mask;
      for (int l = 0; l < LANE_NUM; l++)
         mask[l] = (strobe_row*LANE_NUM + l) < store_vl;
      return mask;
   endfunction

   ////////////////////
   // Checks
   ////////////////////
   for (genvar l = 0; l < LANE_NUM; l++)
   begin : g_store_chk
      assert property (@(negedge clk_i) disable iff (!rst_i)
         !store_valid_o[l] || store_data_o[l] == expected_elem(l))
      else
         report_failure($sformatf("Fail: time %0t store_data_o[%0d] = %h, expected %h",
                                  $time, l, store_data_o[l], expected_elem(l)));
   end

   assert property (@(negedge clk_i) disable iff (!rst_i)
      !(|store_valid_o) || store_valid_o == expected_mask())
   else
      report_failure($sformatf("Fail: time %0t store_valid_o = %b, expected %b",
                               $time, store_valid_o, expected_mask()));

   assert property (@(negedge clk_i) disable iff (!rst_i) !(ready_o && |store_valid_o))
   else
      report_failure("A store strobe came while the unit was idle");

   assert property (@(negedge clk_i) disable iff (!rst_i)
      !ready_for_load_o || (cur_inst == INST_LOAD && !ready_o))
   else
      report_failure("ready_for_load_o was high outside a load");

   task automatic wait_ready();
      @(negedge clk_i);
      while (!ready_o)
         @(negedge clk_i);
   endtask

   // Returns on the edge that accepts the start
   task automatic start_inst(input inst_e inst, input logic [VREG_W-1:0] vd, vs1, vs2,
                             input logic [VL_W-1:0] vl, input alu_op_e op,
                             input op2_sel_e sel, input logic [DATA_W-1:0] scalar,
                             input logic [IMM_W-1:0] imm);
      wait_ready();
      @(posedge clk_i);
      cur_inst = inst;
      start_i   <= 1'b1;
      inst_i    <= inst;
      vd_i      <= vd;
      vs1_i     <= vs1;
      vs2_i     <= vs2;
      vl_i      <= vl;
      alu_op_i  <= op;
      op2_sel_i <= sel;
      scalar_i  <= scalar;
      imm_i     <= imm;
      @(posedge clk_i);
      start_i <= 1'b0;
   endtask

   task automatic load_vec(input logic [VREG_W-1:0] vd, input logic [VL_W-1:0] vl);
      logic [DATA_W-1:0] vals [LANE_NUM*ROWS_MAX];
      int                row;
      logic              taken;
      for (int e = 0; e < LANE_NUM*ROWS_MAX; e++)
         vals[e] = $random(seed);
      predict_load(vd, vl, vals);
      row = 0;
      start_inst(INST_LOAD, vd, '0, '0, vl, ALU_ADD, OP2_VEC, '0, '0);
      while (row < (vl + LANE_NUM - 1) / LANE_NUM)
      begin
         load_valid_i <= ($random(seed) & 3) != 0;         // Idle roughly one cycle in four
         for (int l = 0; l < LANE_NUM; l++)
            load_data_i[l] <= vals[row*LANE_NUM + l];
         @(negedge clk_i);
         taken = load_valid_i && ready_for_load_o;
         @(posedge clk_i);
         if (taken)
            row++;
      end
      load_valid_i <= 1'b0;
   endtask

   task automatic store_vec(input logic [VREG_W-1:0] vs2, input logic [VL_W-1:0] vl);
      wait_ready();
      store_reg = vs2;
      store_vl  = vl;
      start_inst(INST_STORE, '0, '0, vs2, vl, ALU_ADD, OP2_VEC, '0, '0);
      wait_ready();
      assert (strobe_cnt == vl)
      else
         report_failure($sformatf("Fail: time %0t store strobe count = %0d, expected %0d",
                                  $time, strobe_cnt, vl));
   endtask

   task automatic arith_vec(input logic [VREG_W-1:0] vd, vs1, vs2,
                            input logic [VL_W-1:0] vl, input alu_op_e op,
                            input op2_sel_e sel);
      logic [DATA_W-1:0] scalar;
      logic [IMM_W-1:0]  imm;
      scalar = $random(seed);
      imm    = IMM_W'($random(seed));
      predict_arith(vd, vs1, vs2, vl, op, sel, scalar, imm);
      start_inst(INST_ARITH, vd, vs1, vs2, vl, op, sel, scalar, imm);
   endtask

   task automatic slide_vec(input logic [VREG_W-1:0] vd, vs2, input logic [VL_W-1:0] vl);
      logic [DATA_W-1:0] scalar;
      scalar = $random(seed);
      predict_slide(vd, vs2, vl, scalar);
      start_inst(INST_SLIDE, vd, '0, vs2, vl, ALU_ADD, OP2_VEC, scalar, '0);
   endtask

   ////////////////////
   // Sequence
   ////////////////////
   initial
   begin
      logic [VL_W-1:0] vl;
      int              k;
      rst_i        = 1'b0;
      start_i      = 1'b0;
      inst_i       = INST_LOAD;
      vd_i         = '0;
      vs1_i        = '0;
      vs2_i        = '0;
      vl_i         = '0;
      alu_op_i     = ALU_ADD;
      op2_sel_i    = OP2_VEC;
      scalar_i     = '0;
      imm_i        = '0;
      load_valid_i = 1'b0;
      load_data_i  = '0;
      repeat (2) @(posedge clk_i);
      rst_i <= 1'b1;
      @(negedge clk_i);
      assert (ready_o)
      else
         report_failure($sformatf("Fail: time %0t ready_o = %b, expected 1", $time, ready_o));
      assert (!ready_for_load_o)
      else
         report_failure($sformatf("Fail: time %0t ready_for_load_o = %b, expected 0",
                                  $time, ready_for_load_o));
      assert (store_valid_o == '0)
      else
         report_failure($sformatf("Fail: time %0t store_valid_o = %b, expected 0",
                                  $time, store_valid_o));

      for (int r = 0; r < VREG_NUM; r++)
         load_vec(r, 16);
      for (int r = 0; r < VREG_NUM; r++)
         store_vec(r, 16);

      // Every opcode against every operand source
      k = 0;
      for (int op = 0; op < 7; op++)
      begin
         for (int sel = 0; sel < 3; sel++)
         begin
            arith_vec(4 + k % 4, k % 4, (k + 1) % 4, 16, alu_op_e'(op), op2_sel_e'(sel));
            store_vec(4 + k % 4, 16);
            k++;
         end
      end

      slide_vec(6, 1, 16);
      store_vec(6, 16);
      slide_vec(7, 7, 16);                                  // In place
      store_vec(7, 16);

      // Tails above vl must survive
      for (int i = 0; i < 4; i++)
      begin
         vl = VL_W'(($random(seed) & 15) + 1);
         load_vec(3, vl);
         store_vec(3, 16);
         arith_vec(2, 0, 1, vl, alu_op_e'(i), op2_sel_e'(i % 3));
         store_vec(2, 16);
         store_vec(2, vl);
         slide_vec(5, 3, vl);
         store_vec(5, 16);
      end

      wait_ready();
      $display("Test completed successfully");
      $finish;
   end

endmodule
